// File: busPkg.sv
`default_nettype none

package busPkg;

    // Data region, byte addresses
    localparam logic [31:0] DataStart = 32'h0000_0000;
    localparam logic [31:0] DataEnd   = 32'h0000_1000;

    // Device region holding both timers
    localparam logic [31:0] DevStart = 32'h0000_7F00;
    localparam logic [31:0] DevEnd   = 32'h0000_7F20;

    // Timer windows, three registers each
    localparam logic [31:0] Timer0Start = 32'h0000_7F00;
    localparam logic [31:0] Timer0End   = 32'h0000_7F0C;
    localparam logic [31:0] Timer1Start = 32'h0000_7F10;
    localparam logic [31:0] Timer1End   = 32'h0000_7F1C;

    // Data memory depth, must cover DataStart..DataEnd
    localparam int DmWords = 1024;
    localparam int DmIdxW  = $clog2(DmWords);

    // Word offsets inside a timer window
    localparam logic [1:0] RegCtrl   = 2'd0;
    localparam logic [1:0] RegPreset = 2'd1;
    localparam logic [1:0] RegCount  = 2'd2;

    // Control register bits
    localparam int CtrlEnable  = 0;
    localparam int CtrlModeLo  = 1;
    localparam int CtrlModeHi  = 2;
    localparam int CtrlIntMask = 3;

    // CPU data port request
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wData;
        logic [3:0]  we;
    } cpuReq_t;

    // Device request, word addressed with a full-word strobe
    typedef struct packed {
        logic [29:0] addr;
        logic [31:0] wData;
        logic        we;
    } devReq_t;

    // Hardware interrupt lines 7..2 as seen by the processor
    typedef logic [7:2] hwInt_t;

    typedef enum logic [1:0] {
        TmIdle,
        TmLoad,
        TmCount,
        TmInt
    } timerState_t;

    typedef enum logic [1:0] {
        ModeOneShot = 2'd0,
        ModeReload  = 2'd1
    } timerMode_t;

endpackage

`default_nettype wire

// File: dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input  wire         clk,
    input  wire         arstN,
    input  wire  [3:0]  we,
    input  wire  [31:0] addr,
    input  wire  [31:0] wData,
    output logic [31:0] rData
);
    import busPkg::*;

    logic [31:0]       mem [DmWords];
    logic [DmIdxW-1:0] wordIdx;

    // Word index, byte offset bits are ignored
    assign wordIdx = addr[DmIdxW+1:2];

    // Byte lane writes, held off while reset is asserted
    always_ff @(posedge clk) begin
        if (arstN) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (we[lane]) begin
                    mem[wordIdx][8*lane +: 8] <= wData[8*lane +: 8];
                end
            end
        end
    end

    // Asynchronous read
    assign rData = mem[wordIdx];

endmodule

`default_nettype wire

// File: countTimer.sv
`timescale 1ns/1ps
`default_nettype none

module countTimer (
    input  wire                  clk,
    input  wire                  arstN,
    input  wire busPkg::devReq_t req,
    output logic [31:0]          rData,
    output logic                 irq
);
    import busPkg::*;

    logic [3:0]  ctrl;
    logic [31:0] preset;
    logic [31:0] count;
    timerState_t state;
    timerState_t stateNext;
    timerMode_t  mode;
    logic [1:0]  regSel;
    logic        ctrlWr;
    logic        presetWr;
    logic        countDone;

    // Register offset inside the window
    assign regSel   = req.addr[1:0];
    assign ctrlWr   = req.we && (regSel == RegCtrl);
    assign presetWr = req.we && (regSel == RegPreset);

    assign mode      = timerMode_t'(ctrl[CtrlModeHi:CtrlModeLo]);
    assign countDone = (state == TmCount) && (count == '0);

    // Next state
    always_comb begin
        stateNext = state;
        if (ctrlWr) begin
            // A control write always restarts or stops the timer
            stateNext = req.wData[CtrlEnable] ? TmLoad : TmIdle;
        end else begin
            case (state)
                TmIdle: begin
                    stateNext = TmIdle;
                end
                TmLoad: begin
                    stateNext = TmCount;
                end
                TmCount: begin
                    if (count == '0) begin
                        stateNext = TmInt;
                    end
                end
                TmInt: begin
                    // One-shot holds here until software rewrites ctrl
                    if (mode == ModeReload) begin
                        stateNext = TmLoad;
                    end
                end
                default: begin
                    stateNext = TmIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= TmIdle;
            ctrl   <= '0;
            preset <= '0;
            count  <= '0;
        end else begin
            state <= stateNext;

            if (ctrlWr) begin
                ctrl <= req.wData[3:0];
            end else if (countDone && (mode == ModeOneShot)) begin
                ctrl[CtrlEnable] <= 1'b0;
            end

            // Takes effect at the next load
            if (presetWr) begin
                preset <= req.wData;
            end

            if (!ctrlWr) begin
                if (state == TmLoad) begin
                    count <= preset;
                end else if ((state == TmCount) && (count != '0)) begin
                    count <= count - 32'd1;
                end
            end
        end
    end

    assign irq = (state == TmInt) && ctrl[CtrlIntMask];

    // Register read, count is read only
    always_comb begin
        case (regSel)
            RegCtrl:   rData = {28'd0, ctrl};
            RegPreset: rData = preset;
            RegCount:  rData = count;
            default:   rData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: southBridge.sv
`timescale 1ns/1ps
`default_nettype none

module southBridge (
    input  wire busPkg::devReq_t devReq,
    output logic [31:0]          devRData,
    output busPkg::devReq_t      t0Req,
    input  wire  [31:0]          t0RData,
    input  wire                  t0Irq,
    output busPkg::devReq_t      t1Req,
    input  wire  [31:0]          t1RData,
    input  wire                  t1Irq,
    input  wire                  extInt,
    output busPkg::hwInt_t       hwInt
);
    import busPkg::*;

    logic [31:0] byteAddr;
    logic        sel0;
    logic        sel1;

    // Back to a byte address for the window compare
    assign byteAddr = {devReq.addr, 2'b00};

    assign sel0 = (byteAddr >= Timer0Start) && (byteAddr < Timer0End);
    assign sel1 = (byteAddr >= Timer1Start) && (byteAddr < Timer1End);

    // Address and data go to both timers, only the strobe is steered
    always_comb begin
        t0Req    = devReq;
        t0Req.we = devReq.we && sel0;
    end

    always_comb begin
        t1Req    = devReq;
        t1Req.we = devReq.we && sel1;
    end

    // Gaps between windows read zero
    always_comb begin
        if (sel0) begin
            devRData = t0RData;
        end else if (sel1) begin
            devRData = t1RData;
        end else begin
            devRData = '0;
        end
    end

    // Bits 7..5 are not wired to any source
    assign hwInt = {3'b000, extInt, t1Irq, t0Irq};

endmodule

`default_nettype wire

// File: northBridge.sv
`timescale 1ns/1ps
`default_nettype none

module northBridge (
    input  wire busPkg::cpuReq_t cpuReq,
    output logic [31:0]          rData,
    output logic [3:0]           dmWe,
    output logic [31:0]          dmAddr,
    output logic [31:0]          dmWData,
    input  wire  [31:0]          dmRData,
    output busPkg::devReq_t      devReq,
    input  wire  [31:0]          devRData
);
    import busPkg::*;

    logic inData;
    logic inDev;

    // Region decode only, timer selection is left to the south bridge
    assign inData = (cpuReq.addr >= DataStart) && (cpuReq.addr < DataEnd);
    assign inDev  = (cpuReq.addr >= DevStart) && (cpuReq.addr < DevEnd);

    // Data memory side
    assign dmAddr  = cpuReq.addr;
    assign dmWData = cpuReq.wData;
    assign dmWe    = inData ? cpuReq.we : 4'b0000;

    // Device side, full-word writes only
    always_comb begin
        devReq.addr  = cpuReq.addr[31:2];
        devReq.wData = cpuReq.wData;
        devReq.we    = inDev && (&cpuReq.we);
    end

    // Unmapped addresses read zero
    always_comb begin
        if (inData) begin
            rData = dmRData;
        end else if (inDev) begin
            rData = devRData;
        end else begin
            rData = '0;
        end
    end

endmodule

`default_nettype wire

// File: bridgeTop.sv
`timescale 1ns/1ps
`default_nettype none

module bridgeTop (
    input  wire                  clk,
    input  wire                  arstN,
    input  wire busPkg::cpuReq_t cpuReq,
    input  wire                  extInt,
    output logic [31:0]          rData,
    output busPkg::hwInt_t       hwInt
);
    import busPkg::*;

    // Memory port
    logic [3:0]  dmWe;
    logic [31:0] dmAddr;
    logic [31:0] dmWData;
    logic [31:0] dmRData;

    // Device bus
    devReq_t     devReq;
    logic [31:0] devRData;

    // Timer ports
    devReq_t     t0Req;
    devReq_t     t1Req;
    logic [31:0] t0RData;
    logic [31:0] t1RData;
    logic        t0Irq;
    logic        t1Irq;

    northBridge north (
        .cpuReq   (cpuReq),
        .rData    (rData),
        .dmWe     (dmWe),
        .dmAddr   (dmAddr),
        .dmWData  (dmWData),
        .dmRData  (dmRData),
        .devReq   (devReq),
        .devRData (devRData)
    );

    dataMem dataMemory (
        .clk   (clk),
        .arstN (arstN),
        .we    (dmWe),
        .addr  (dmAddr),
        .wData (dmWData),
        .rData (dmRData)
    );

    southBridge south (
        .devReq   (devReq),
        .devRData (devRData),
        .t0Req    (t0Req),
        .t0RData  (t0RData),
        .t0Irq    (t0Irq),
        .t1Req    (t1Req),
        .t1RData  (t1RData),
        .t1Irq    (t1Irq),
        .extInt   (extInt),
        .hwInt    (hwInt)
    );

    countTimer timer0 (
        .clk   (clk),
        .arstN (arstN),
        .req   (t0Req),
        .rData (t0RData),
        .irq   (t0Irq)
    );

    countTimer timer1 (
        .clk   (clk),
        .arstN (arstN),
        .req   (t1Req),
        .rData (t1RData),
        .irq   (t1Irq)
    );

endmodule

`default_nettype wire

// File: tbBridge.sv
`timescale 1ns/1ps
`default_nettype none

module tbBridge;
    import busPkg::*;

    // Whole sequence needs well under a thousand cycles
    localparam int CycleLimit = 20000;

    logic        clk;
    logic        arstN;
    cpuReq_t     cpuReq;
    logic        extInt;
    logic [31:0] rData;
    hwInt_t      hwInt;

    // Reference model state
    logic [31:0] shadowMem [DmWords];
    bit          touched [DmWords];
    logic [3:0]  shadowCtrl [2];
    logic [31:0] shadowPreset [2];
    logic        expIrq [2];

    integer      seed;
    logic [31:0] rnd;
    int          cycleCount;

    bridgeTop bridgeTop_i (
        .clk    (clk),
        .arstN  (arstN),
        .cpuReq (cpuReq),
        .extInt (extInt),
        .rData  (rData),
        .hwInt  (hwInt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            failRun("Timeout: the run did not finish within the cycle limit");
        end
    end

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            failRun($sformatf("Error in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic checkInt(input string name, input hwInt_t exp, input hwInt_t act);
        if (act !== exp) begin
            failRun($sformatf("Error in %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic checkCtrl(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            failRun($sformatf("Error in %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic logic [31:0] timerBase(input int t);
        return (t == 0) ? Timer0Start : Timer1Start;
    endfunction

    function automatic int timerIndex(input logic [31:0] addr);
        int t;
        t = -1;
        if (addr >= Timer0Start && addr < Timer0End) begin
            t = 0;
        end else if (addr >= Timer1Start && addr < Timer1End) begin
            t = 1;
        end
        return t;
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (be[lane]) begin
                res[8*lane +: 8] = data[8*lane +: 8];
            end
        end
        return res;
    endfunction

    // Expected read data from the address map and the shadow state
    function automatic logic [31:0] expRead(input logic [31:0] addr);
        logic [31:0] res;
        int          t;
        res = 32'd0;
        t = timerIndex(addr);
        if (addr >= DataStart && addr < DataEnd) begin
            res = shadowMem[addr[11:2]];
        end else if (t >= 0) begin
            // Count is only read this way while it rests at zero
            if (addr[3:2] == RegCtrl) begin
                res = {28'd0, shadowCtrl[t]};
            end else if (addr[3:2] == RegPreset) begin
                res = shadowPreset[t];
            end
        end
        return res;
    endfunction

    function automatic hwInt_t expHwInt(input logic irq0, input logic irq1, input logic ext);
        hwInt_t v;
        v = '0;
        v[2] = irq0;
        v[3] = irq1;
        v[4] = ext;
        return v;
    endfunction

    task automatic modelWrite(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        int t;
        t = timerIndex(addr);
        if (addr >= DataStart && addr < DataEnd) begin
            shadowMem[addr[11:2]] = mergeBytes(shadowMem[addr[11:2]], data, be);
            touched[addr[11:2]] = 1'b1;
        end else if (t >= 0 && be == 4'hF) begin
            if (addr[3:2] == RegCtrl) begin
                shadowCtrl[t] = data[3:0];
            end else if (addr[3:2] == RegPreset) begin
                shadowPreset[t] = data;
            end
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the write edge
    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
        modelWrite(addr, data, be);
        cpuReq.addr  = addr;
        cpuReq.wData = data;
        cpuReq.we    = be;
        @(negedge clk);
        cpuReq.we = 4'h0;
    endtask

    task automatic busRead(input logic [31:0] addr, output logic [31:0] data);
        cpuReq.addr = addr;
        cpuReq.we   = 4'h0;
        #1;
        data = rData;
        @(negedge clk);
    endtask

    task automatic checkMemory(input string tag);
        logic [31:0] data;
        for (int i = 0; i < DmWords; i++) begin
            if (touched[i]) begin
                busRead(i * 4, data);
                checkWord($sformatf("%s word %0d", tag, i), expRead(i * 4), data);
            end
        end
    endtask

    task automatic checkTimerRegs(input int t, input string tag);
        logic [31:0] data;
        busRead(timerBase(t), data);
        checkCtrl($sformatf("%s timer%0d ctrl", tag, t), shadowCtrl[t], data[3:0]);
        checkWord($sformatf("%s timer%0d ctrl upper", tag, t), 32'd0, {4'd0, data[31:4]});
        busRead(timerBase(t) + 32'd4, data);
        checkWord($sformatf("%s timer%0d preset", tag, t), expRead(timerBase(t) + 32'd4), data);
    endtask

    task automatic probeHole(input logic [31:0] addr);
        logic [31:0] data;
        rnd = $random(seed);
        busWrite(addr, rnd, 4'hF);
        busRead(addr, data);
        checkWord($sformatf("hole %h", addr), expRead(addr), data);
    endtask

    task automatic runOneShot(input int t, input int p, input logic mask);
        logic [31:0] data;
        busWrite(timerBase(t) + 32'd4, p, 4'hF);
        // Mask, one-shot mode, enable
        busWrite(timerBase(t), {28'd0, mask, 2'b00, 1'b1}, 4'hF);
        repeat (p + 2) @(negedge clk);
        expIrq[t] = mask;
        shadowCtrl[t][CtrlEnable] = 1'b0;
        repeat (3) @(negedge clk);
        busRead(timerBase(t) + 32'd8, data);
        checkWord($sformatf("timer%0d count after one-shot", t), 32'd0, data);
        busRead(timerBase(t), data);
        checkCtrl($sformatf("timer%0d ctrl after one-shot", t), shadowCtrl[t], data[3:0]);
        busWrite(timerBase(t), {28'd0, mask, 3'b000}, 4'hF);
        expIrq[t] = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic runReload(input int t, input int p);
        int   pulses;
        int   total;
        logic prevBit;
        logic bitNow;
        pulses = 0;
        prevBit = 1'b0;
        total = 3 * (p + 3);
        busWrite(timerBase(t) + 32'd4, p, 4'hF);
        busWrite(timerBase(t), 32'hB, 4'hF);
        for (int i = 0; i < total; i++) begin
            // TmInt recurs every p+3 edges after the first one
            expIrq[t] = (i >= p + 2) && ((i - p - 2) % (p + 3) == 0);
            cpuReq.addr = timerBase(t) + 32'd8;
            #1;
            bitNow = hwInt[2 + t];
            if (rData > p) begin
                failRun($sformatf("Error in timer%0d reload count: expected at most %0d, actual %0d",
                                  t, p, rData));
            end
            if (bitNow && !prevBit) begin
                pulses++;
            end
            prevBit = bitNow;
            @(negedge clk);
        end
        if (pulses < 2) begin
            failRun($sformatf("Error in timer%0d reload pulses: expected at least 2, actual %0d",
                              t, pulses));
        end
        expIrq[t] = (total - p - 2) % (p + 3) == 0;
        busWrite(timerBase(t), 32'h8, 4'hF);
        expIrq[t] = 1'b0;
    endtask

    // Compares hwInt every cycle, after the drive and before the next edge
    always @(negedge clk) begin
        #2;
        checkInt("hwInt", expHwInt(expIrq[0], expIrq[1], extInt), hwInt);
    end

    initial begin
        logic [31:0] data;
        int          idx;
        logic [3:0]  be;
        arstN = 1'b0;
        cpuReq = '0;
        extInt = 1'b0;
        seed = 57744;
        cycleCount = 0;
        for (int i = 0; i < DmWords; i++) begin
            touched[i] = 1'b0;
        end
        for (int t = 0; t < 2; t++) begin
            shadowCtrl[t] = 4'd0;
            shadowPreset[t] = 32'd0;
            expIrq[t] = 1'b0;
        end
        // Release on the falling edge after the third rising edge
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        // Full-word seed writes, words 0 and 1 fixed for the alias probes
        for (int n = 0; n < 18; n++) begin
            idx = (n < 2) ? n : ($random(seed) & (DmWords - 1));
            rnd = $random(seed);
            busWrite(idx * 4, rnd, 4'hF);
        end
        for (int n = 0; n < 48; n++) begin
            idx = $random(seed) & (DmWords - 1);
            while (!touched[idx]) begin
                idx = (idx + 1) % DmWords;
            end
            rnd = $random(seed);
            be = rnd[3:0];
            rnd = $random(seed);
            busWrite(idx * 4 + (n % 4), rnd, be);
        end
        checkMemory("byte merge");

        // Enable bit stays clear so neither timer starts
        for (int t = 0; t < 2; t++) begin
            rnd = $random(seed);
            busWrite(timerBase(t) + 32'd4, rnd, 4'hF);
            busWrite(timerBase(t), (t == 0) ? 32'hA : 32'h8, 4'hF);
            busWrite(timerBase(t) + 32'd8, 32'hFFFF_FFFF, 4'hF);
            checkTimerRegs(t, "register");
            busRead(timerBase(t) + 32'd8, data);
            checkWord($sformatf("timer%0d count after write", t), 32'd0, data);
        end

        probeHole(DataEnd);
        probeHole(32'h0000_2004);
        probeHole(32'h0000_7EFC);
        probeHole(32'h0000_7F0C);
        probeHole(32'h0000_7F1C);
        probeHole(DevEnd);
        probeHole(32'hFFFF_FFFC);
        busWrite(Timer0Start, 32'hF, 4'b0111);
        busWrite(Timer1Start + 32'd4, 32'h1234_5678, 4'b0011);
        checkMemory("after unmapped writes");
        checkTimerRegs(0, "after partial writes");
        checkTimerRegs(1, "after partial writes");

        runOneShot(0, 5, 1'b1);
        runOneShot(1, 9, 1'b1);
        extInt = 1'b1;
        runOneShot(1, 3, 1'b0);
        extInt = 1'b0;
        runReload(0, 4);
        extInt = 1'b1;
        repeat (4) @(negedge clk);
        extInt = 1'b0;
        repeat (2) @(negedge clk);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
busPkg.sv
dataMem.sv
countTimer.sv
southBridge.sv
northBridge.sv
bridgeTop.sv
tbBridge.sv

// File: Bender.yml
package:
  name: bridge_subsystem

sources:
  - busPkg.sv
  - dataMem.sv
  - countTimer.sv
  - southBridge.sv
  - northBridge.sv
  - bridgeTop.sv
  - target: simulation
    files:
      - tbBridge.sv
